// File: bench/fetch_tb.sv
/*
 * Fetch front end testbench.
 * Loads random packets through the loader port, steers fetch with
 * redirects and checks every packet handed to the decoder.
 */

`timescale 1ns/1ps
`default_nettype none

module fetch_tb;

    import fetch_pkg::*;

    localparam int mem_packets = 256;
    localparam int entry_bits  = 1 + CPU_ADDR_BITS + PACKET_BITS;

    logic                     clk         = 1'b0;
    logic                     rst         = 1'b1;
    logic                     flush       = 1'b0;
    pc_sel_t                  pc_sel      = PC_SEQ;
    logic [CPU_ADDR_BITS-1:0] rob_pc      = '0;
    logic                     load_val    = 1'b0;
    logic                     load_rdy;
    logic [CPU_ADDR_BITS-1:0] load_addr   = '0;
    logic [PACKET_BITS-1:0]   load_data   = '0;
    logic                     decoder_rdy = 1'b0;
    logic                     fetch_val;
    logic [CPU_INST_BITS-1:0] insts    [PIPE_WIDTH];
    logic [CPU_ADDR_BITS-1:0] inst_pcs [PIPE_WIDTH];

    logic [PACKET_BITS-1:0]   model [mem_packets];   // mirror of every loader write.
    logic [entry_bits-1:0]    exp_q [$];             // {check data, pc, packet}.
    logic                     head_val = 1'b0;
    logic                     head_chk = 1'b0;
    logic [CPU_ADDR_BITS-1:0] head_pc  = '0;
    logic [PACKET_BITS-1:0]   head_pkt = '0;
    logic [CPU_ADDR_BITS-1:0] seen_pc  = '0;         // outputs as they stood before the edge.
    logic [PACKET_BITS-1:0]   seen_pkt = '0;
    integer                   seed = 32'h0875eaf4;
    int                       errors = 0;
    int                       tests_run = 0;
    int                       tests_failed = 0;
    int                       errs_at_start = 0;
    logic                     timed_out = 1'b0;
    string                    test_name = "reset";

    always #4 clk = ~clk;

    fetch_top #(.mem_packets(mem_packets), .ib_depth(4), .pc_reset(PC_RESET)) fetch_top_i (
        .clk(clk), .rst(rst), .flush(flush), .pc_sel(pc_sel), .rob_pc(rob_pc),
        .load_val(load_val), .load_rdy(load_rdy), .load_addr(load_addr),
        .load_data(load_data), .decoder_rdy(decoder_rdy), .fetch_val(fetch_val),
        .insts(insts), .inst_pcs(inst_pcs)
    );

    // ##################################################################
    // checks on the DUT outputs
    // ##################################################################
    a_quiet_reset: assert property (@(posedge clk) (rst || $fell(rst)) |=> !fetch_val)
        else begin
            errors++;
            $display("error %s: fetch_val expected 0 actual 1", test_name);
        end

    // the memory port stays closed to the loader while reset is held.
    a_loader_reset: assert property (@(posedge clk) rst |=> !load_rdy)
        else begin
            errors++;
            $display("error %s: load_rdy expected 0 actual 1", test_name);
        end

    a_pcs: assert property (@(posedge clk) disable iff (rst)
        (fetch_val && decoder_rdy && head_val) |->
            (inst_pcs[0] == head_pc && inst_pcs[1] == head_pc + 32'd4))
        else begin
            errors++;
            $display("error %s: pc expected %h actual %h", test_name, head_pc, seen_pc);
        end

    a_insts: assert property (@(posedge clk) disable iff (rst)
        (fetch_val && decoder_rdy && head_val && head_chk) |->
            ({insts[1], insts[0]} == head_pkt))
        else begin
            errors++;
            $display("error %s: packet expected %h actual %h", test_name, head_pkt, seen_pkt);
        end

    // ##################################################################
    // stimulus tasks
    // ##################################################################
    function automatic int pkt_index(input logic [CPU_ADDR_BITS-1:0] addr);
        return int'((addr / PACKET_BYTES) % mem_packets);
    endfunction

    task automatic set_head();
        head_val = (exp_q.size() > 0);
        if (head_val) {head_chk, head_pc, head_pkt} = exp_q[0];
    endtask

    // n packets in sequence from start, the data taken from the model.
    task automatic expect_run(input logic [CPU_ADDR_BITS-1:0] start, input int n,
                              input logic chk);
        for (int i = 0; i < n; i++) begin
            exp_q.push_back({chk, start + 32'(i * PACKET_BYTES),
                             model[pkt_index(start + 32'(i * PACKET_BYTES))]});
        end
        set_head();
    endtask

    // takes exactly the expected packets, with random stalls if random_rdy is set.
    task automatic drain(input logic random_rdy, input int limit);
        int          waited;
        logic        took;
        logic [31:0] rnd;
        waited = 0;
        took = 1'b0;
        while (exp_q.size() > 0 && !timed_out) begin
            @(negedge clk);
            if (took) begin
                void'(exp_q.pop_front());   // handed over at the last rising edge.
                set_head();
            end
            rnd = $random(seed);
            decoder_rdy = (exp_q.size() > 0) && (!random_rdy || rnd[0]);
            #1;
            took = fetch_val && decoder_rdy;
            seen_pc = inst_pcs[0];
            seen_pkt = {insts[1], insts[0]};
            waited++;
            if (waited > limit && exp_q.size() > 0) begin
                timed_out = 1'b1;
                decoder_rdy = 1'b0;
                $display("timeout: %s still waits for %0d packets", test_name, exp_q.size());
            end
        end
    endtask

    task automatic load_packet(input logic [CPU_ADDR_BITS-1:0] addr,
                               input logic [PACKET_BITS-1:0] data, inout int done);
        int waited;
        waited = 0;
        @(negedge clk);
        load_val = !timed_out;
        load_addr = addr;
        load_data = data;
        #1;
        while (load_val && !load_rdy && waited < 20) begin
            @(negedge clk);
            #1;
            waited++;
        end
        if (load_val && load_rdy) begin
            @(posedge clk);
            model[pkt_index(addr)] = data;   // the memory takes the write at this edge.
            done++;
        end else if (load_val) begin
            timed_out = 1'b1;
            $display("timeout: loader write to %h was never accepted", addr);
        end
        @(negedge clk);
        load_val = 1'b0;
    endtask

    task automatic redirect(input logic [CPU_ADDR_BITS-1:0] target);
        @(negedge clk);
        flush = 1'b1;
        pc_sel = PC_REDIRECT;
        rob_pc = target;
        @(negedge clk);
        flush = 1'b0;
        pc_sel = PC_SEQ;
    endtask

    task automatic end_test(input string next_name);
        tests_run++;
        if (errors != errs_at_start || timed_out) tests_failed++;
        $display("test %s: %s", test_name,
                 (errors == errs_at_start && !timed_out) ? "pass" : "fail");
        errs_at_start = errors;
        test_name = next_name;
    endtask

    // ##################################################################
    // test sequence
    // ##################################################################
    initial begin
        logic [CPU_ADDR_BITS-1:0] next_pc;
        logic [CPU_ADDR_BITS-1:0] target;
        int                       writes;
        writes = 0;
        repeat (5) @(negedge clk);
        rst = 1'b0;
        expect_run(PC_RESET, 1, 1'b0);   // memory is not loaded yet, so only the PC counts.
        drain(1'b0, 50);
        end_test("sequential");

        for (int i = 0; i < mem_packets; i++) begin
            load_packet(32'(i * PACKET_BYTES), {$random(seed), $random(seed)}, writes);
        end
        redirect(PC_RESET);
        expect_run(PC_RESET, 12, 1'b1);
        drain(1'b0, 100);
        next_pc = PC_RESET + 32'(12 * PACKET_BYTES);
        end_test("redirect");

        for (int r = 0; r < 3; r++) begin
            expect_run(next_pc, 3, 1'b1);
            drain(1'b0, 50);
            target = $random(seed) & 32'((mem_packets - 1) * PACKET_BYTES);
            redirect(target);
            expect_run(target, 6, 1'b1);
            drain(1'b0, 80);
            next_pc = target + 32'(6 * PACKET_BYTES);
        end
        end_test("backpressure");

        expect_run(next_pc, 40, 1'b1);
        drain(1'b1, 1000);
        next_pc = next_pc + 32'(40 * PACKET_BYTES);
        end_test("loader");

        // rewrite half a memory ahead, far from the packets being fetched.
        target = next_pc + 32'(mem_packets * PACKET_BYTES / 2);
        writes = 0;
        expect_run(next_pc, 30, 1'b1);
        fork
            drain(1'b1, 1000);
            for (int k = 0; k < 8; k++) begin
                load_packet(target + 32'(k * PACKET_BYTES), {$random(seed), $random(seed)},
                            writes);
            end
        join
        a_writes_done: assert (writes == 8) else begin
            errors++;
            $display("error %s: writes expected 8 actual %0d", test_name, writes);
        end
        redirect(target);
        expect_run(target, 8, 1'b1);
        drain(1'b0, 80);
        end_test("");

        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0 && !timed_out) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# Builds the fetch front end testbench with Verilator and runs it.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module fetch_tb -f verilog.f \
    -o fetch_tb_sim

./obj_dir/fetch_tb_sim | tee sim.log

# the log decides the result.
if grep -qx "TEST OK" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

// File: source/fetch.sv
/*
 * Fetch stage.
 * Generates the address of the next two-instruction packet, follows
 * redirects from the reorder buffer and tags each memory response with
 * its PC before it enters the instruction buffer.
 */

`timescale 1ns/1ps
`default_nettype none

module fetch #(
    parameter logic [fetch_pkg::CPU_ADDR_BITS-1:0] pc_reset = fetch_pkg::PC_RESET,
    parameter int ib_depth = 4
) (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                flush,

    // redirect from the reorder buffer.
    input  fetch_pkg::pc_sel_t                  pc_sel,
    input  logic [fetch_pkg::CPU_ADDR_BITS-1:0] rob_pc,

    // request to the memory arbiter.
    input  logic                                imem_req_rdy,
    output logic                                imem_req_val,
    output logic [fetch_pkg::CPU_ADDR_BITS-1:0] imem_req_addr,

    // response from the instruction memory.
    output logic                                imem_rec_rdy,
    input  logic                                imem_rec_val,
    input  logic [fetch_pkg::PACKET_BITS-1:0]   imem_rec_packet,

    // decoder side.
    input  logic                                decoder_rdy,
    output logic                                fetch_val,
    output logic [fetch_pkg::CPU_INST_BITS-1:0] insts    [fetch_pkg::PIPE_WIDTH],
    output logic [fetch_pkg::CPU_ADDR_BITS-1:0] inst_pcs [fetch_pkg::PIPE_WIDTH]
);

    import fetch_pkg::*;

    logic [CPU_ADDR_BITS-1:0] pc;       // address of the next packet to request.
    logic [CPU_ADDR_BITS-1:0] rec_pc;   // PC of the response that follows.
    logic                     redirect;
    logic                     req_fire;

    assign redirect = flush && (pc_sel == PC_REDIRECT);

    // a redirect takes effect on the request of the same cycle.
    assign imem_req_addr = redirect ? rob_pc : pc;

    // only ask for a packet when the buffer can take its response.
    assign imem_req_val = imem_req_rdy && imem_rec_rdy;
    assign req_fire     = imem_req_val && imem_req_rdy;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= pc_reset;
        end else if (req_fire) begin
            pc <= imem_req_addr + CPU_ADDR_BITS'(PACKET_BYTES);
        end else if (redirect) begin
            pc <= rob_pc;   // redirect seen while the port was busy.
        end
    end

    // the memory answers one request at a time, so one tag is enough.
    always_ff @(posedge clk) begin
        if (req_fire) begin
            rec_pc <= imem_req_addr;
        end
    end

    inst_buffer #(
        .ib_depth(ib_depth)
    ) inst_buffer_i (
        .clk        (clk),
        .rst        (rst),
        .flush      (flush),
        .rec_pc     (rec_pc),
        .rec_val    (imem_rec_val),
        .rec_packet (imem_rec_packet),
        .rec_rdy    (imem_rec_rdy),
        .decoder_rdy(decoder_rdy),
        .fetch_val  (fetch_val),
        .insts      (insts),
        .inst_pcs   (inst_pcs)
    );

endmodule

`default_nettype wire

// File: source/fetch_pkg.sv
/*
 * Fetch front end shared definitions.
 * Widths of addresses, instructions and packets, the reset PC,
 * the next-PC select codes and the memory arbiter grant values.
 */

`default_nettype none

package fetch_pkg;

    // ######################################################################
    // widths
    // ######################################################################
    localparam int CPU_ADDR_BITS = 32;   // byte address width.
    localparam int CPU_INST_BITS = 32;   // one instruction.
    localparam int FETCH_WIDTH   = 2;    // instructions per memory packet.
    localparam int PIPE_WIDTH    = 2;    // slots offered to the decoder.
    localparam int PACKET_BITS   = FETCH_WIDTH * CPU_INST_BITS;
    localparam int PACKET_BYTES  = 8;    // address step from one packet to the next.
    localparam int INST_BYTES    = CPU_INST_BITS / 8;

    // default PC after reset, the top level can override it.
    localparam logic [CPU_ADDR_BITS-1:0] PC_RESET = 32'h0000_0000;

    // ######################################################################
    // encodings
    // ######################################################################

    // next-PC source from the reorder buffer. Unlisted codes behave as PC_SEQ.
    typedef enum logic [2:0] {
        PC_SEQ      = 3'd0,
        PC_REDIRECT = 3'd1
    } pc_sel_t;

    // owner of the single instruction memory port in the current cycle.
    typedef enum logic [1:0] {
        GRANT_NONE  = 2'd0,
        GRANT_LOAD  = 2'd1,
        GRANT_FETCH = 2'd2
    } arb_grant_t;

endpackage

`default_nettype wire

// File: source/fetch_top.sv
/*
 * Fetch front end top level.
 * Connects the fetch stage and the program loader port through the
 * arbiter to the instruction memory, and sets the block parameters.
 */

`timescale 1ns/1ps
`default_nettype none

module fetch_top #(
    parameter int mem_packets = 256,
    parameter int ib_depth    = 4,
    parameter logic [fetch_pkg::CPU_ADDR_BITS-1:0] pc_reset = fetch_pkg::PC_RESET
) (
    input  logic                                clk,
    input  logic                                rst,

    input  logic                                flush,
    input  fetch_pkg::pc_sel_t                  pc_sel,
    input  logic [fetch_pkg::CPU_ADDR_BITS-1:0] rob_pc,

    input  logic                                load_val,
    output logic                                load_rdy,
    input  logic [fetch_pkg::CPU_ADDR_BITS-1:0] load_addr,
    input  logic [fetch_pkg::PACKET_BITS-1:0]   load_data,

    input  logic                                decoder_rdy,
    output logic                                fetch_val,
    output logic [fetch_pkg::CPU_INST_BITS-1:0] insts    [fetch_pkg::PIPE_WIDTH],
    output logic [fetch_pkg::CPU_ADDR_BITS-1:0] inst_pcs [fetch_pkg::PIPE_WIDTH]
);

    import fetch_pkg::*;

    logic                           imem_req_val;
    logic                           imem_req_rdy;
    logic [CPU_ADDR_BITS-1:0]       imem_req_addr;
    logic                           imem_rec_val;
    logic                           imem_rec_rdy;
    logic [PACKET_BITS-1:0]         imem_rec_packet;
    logic                           mem_en;
    logic                           mem_we;
    logic [$clog2(mem_packets)-1:0] mem_addr;
    logic [PACKET_BITS-1:0]         mem_wdata;
    logic                           mem_ready;

    fetch #(
        .pc_reset(pc_reset),
        .ib_depth(ib_depth)
    ) fetch_i (
        .clk(clk), .rst(rst), .flush(flush), .pc_sel(pc_sel), .rob_pc(rob_pc),
        .imem_req_rdy(imem_req_rdy), .imem_req_val(imem_req_val),
        .imem_req_addr(imem_req_addr), .imem_rec_rdy(imem_rec_rdy),
        .imem_rec_val(imem_rec_val), .imem_rec_packet(imem_rec_packet),
        .decoder_rdy(decoder_rdy), .fetch_val(fetch_val),
        .insts(insts), .inst_pcs(inst_pcs)
    );

    imem_arbiter #(.mem_packets(mem_packets)) arbiter_i (
        .clk(clk), .rst(rst),
        .load_val(load_val), .load_addr(load_addr), .load_data(load_data),
        .load_rdy(load_rdy), .fetch_val(imem_req_val), .fetch_addr(imem_req_addr),
        .fetch_rdy(imem_req_rdy), .mem_en(mem_en), .mem_we(mem_we),
        .mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_ready(mem_ready)
    );

    inst_mem #(.mem_packets(mem_packets)) mem_i (
        .clk(clk), .rst(rst), .mem_en(mem_en), .mem_we(mem_we),
        .mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_ready(mem_ready),
        .rsp_val(imem_rec_val), .rsp_packet(imem_rec_packet), .rsp_rdy(imem_rec_rdy)
    );

endmodule

`default_nettype wire

// File: source/imem_arbiter.sv
/*
 * Instruction memory arbiter.
 * Shares the single memory port between the program loader and the
 * fetch stage. The loader always wins. Byte addresses become packet indices.
 */

`timescale 1ns/1ps
`default_nettype none

module imem_arbiter #(
    parameter int mem_packets = 256
) (
    input  logic                                clk,
    input  logic                                rst,

    // program loader, writes only.
    input  logic                                load_val,
    input  logic [fetch_pkg::CPU_ADDR_BITS-1:0] load_addr,
    input  logic [fetch_pkg::PACKET_BITS-1:0]   load_data,
    output logic                                load_rdy,

    // fetch stage, reads only.
    input  logic                                fetch_val,
    input  logic [fetch_pkg::CPU_ADDR_BITS-1:0] fetch_addr,
    output logic                                fetch_rdy,

    // memory port.
    output logic                                mem_en,
    output logic                                mem_we,
    output logic [$clog2(mem_packets)-1:0]      mem_addr,
    output logic [fetch_pkg::PACKET_BITS-1:0]   mem_wdata,
    input  logic                                mem_ready
);

    import fetch_pkg::*;

    localparam int idx_bits = $clog2(mem_packets);
    localparam int off_bits = $clog2(PACKET_BYTES);

    arb_grant_t grant;

    always_comb begin
        if (load_val && mem_ready) begin
            grant = GRANT_LOAD;
        end else if (fetch_val && fetch_rdy) begin
            grant = GRANT_FETCH;
        end else begin
            grant = GRANT_NONE;
        end
    end

    // the memory accepts writes even while a read response is held.
    assign load_rdy  = mem_ready;
    assign fetch_rdy = !load_val && mem_ready;   // a write stalls fetch for one cycle.

    assign mem_en    = (grant != GRANT_NONE);
    assign mem_we    = load_val;
    assign mem_wdata = load_data;
    assign mem_addr  = (grant == GRANT_LOAD) ? load_addr[off_bits +: idx_bits]
                                             : fetch_addr[off_bits +: idx_bits];

    // the memory takes a write in every cycle, so a valid loader owns the port alone.
    a_one_owner: assert property (@(posedge clk) disable iff (rst)
        (load_val && !$past(rst)) |-> (grant == GRANT_LOAD && !fetch_rdy));

endmodule

`default_nettype wire

// File: source/inst_buffer.sv
/*
 * Instruction buffer.
 * Circular FIFO of fetched packets with their PCs. Each entry is offered
 * to the decoder as PIPE_WIDTH instruction slots. A flush empties the
 * queue and discards a memory response that was still in flight.
 */

`timescale 1ns/1ps
`default_nettype none

module inst_buffer #(
    parameter int ib_depth = 4
) (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                flush,

    input  logic [fetch_pkg::CPU_ADDR_BITS-1:0] rec_pc,
    input  logic                                rec_val,
    input  logic [fetch_pkg::PACKET_BITS-1:0]   rec_packet,
    output logic                                rec_rdy,

    input  logic                                decoder_rdy,
    output logic                                fetch_val,
    output logic [fetch_pkg::CPU_INST_BITS-1:0] insts    [fetch_pkg::PIPE_WIDTH],
    output logic [fetch_pkg::CPU_ADDR_BITS-1:0] inst_pcs [fetch_pkg::PIPE_WIDTH]
);

    import fetch_pkg::*;

    localparam int ptr_bits = (ib_depth > 1) ? $clog2(ib_depth) : 1;
    localparam int cnt_bits = $clog2(ib_depth + 1);

    logic [PACKET_BITS-1:0]   pkt_mem [ib_depth];
    logic [CPU_ADDR_BITS-1:0] pc_mem  [ib_depth];
    logic [ptr_bits-1:0]      wr_ptr;
    logic [ptr_bits-1:0]      rd_ptr;
    logic [cnt_bits-1:0]      count;
    logic                     drop;     // next response is stale.
    logic                     wr_en;
    logic                     rd_en;

    function automatic logic [ptr_bits-1:0] ptr_inc(input logic [ptr_bits-1:0] p);
        if (p == ptr_bits'(ib_depth - 1)) begin
            return '0;
        end
        return p + ptr_bits'(1);
    endfunction

    // keep one entry spare for the response that may already be on its way.
    assign rec_rdy   = (int'(count) + 2) <= ib_depth;
    assign fetch_val = (count != '0);

    assign wr_en = rec_val && rec_rdy && !flush && !drop;
    assign rd_en = fetch_val && decoder_rdy && !flush;

    // ######################################################################
    // control
    // ######################################################################
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            drop   <= 1'b0;
        end else begin
            // a response stuck in the memory at the flush is old data.
            drop <= flush && rec_val && !rec_rdy;
            if (flush) begin
                wr_ptr <= '0;
                rd_ptr <= '0;
                count  <= '0;
            end else begin
                if (wr_en) wr_ptr <= ptr_inc(wr_ptr);
                if (rd_en) rd_ptr <= ptr_inc(rd_ptr);
                count <= count + cnt_bits'(wr_en) - cnt_bits'(rd_en);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            pkt_mem[wr_ptr] <= rec_packet;
            pc_mem[wr_ptr]  <= rec_pc;
        end
    end

    // slot i holds the instruction at PC + 4*i, the lowest address in the low bits.
    always_comb begin
        for (int i = 0; i < PIPE_WIDTH; i++) begin
            insts[i]    = pkt_mem[rd_ptr][i*CPU_INST_BITS +: CPU_INST_BITS];
            inst_pcs[i] = pc_mem[rd_ptr] + CPU_ADDR_BITS'(i * INST_BYTES);
        end
    end

    // ######################################################################
    // assertions
    // ######################################################################

    // a full queue shows as equal pointers while entries are still held.
    a_no_write_full: assert property (@(posedge clk) disable iff (rst)
        wr_en |-> !(wr_ptr == rd_ptr && count != '0));

endmodule

`default_nettype wire

// File: source/inst_mem.sv
/*
 * Instruction memory.
 * Packet-wide synchronous RAM with a registered read. A read response is
 * held until it is taken, and no new read is accepted meanwhile.
 */

`timescale 1ns/1ps
`default_nettype none

module inst_mem #(
    parameter int mem_packets = 256
) (
    input  logic                              clk,
    input  logic                              rst,

    input  logic                              mem_en,
    input  logic                              mem_we,
    input  logic [$clog2(mem_packets)-1:0]    mem_addr,
    input  logic [fetch_pkg::PACKET_BITS-1:0] mem_wdata,
    output logic                              mem_ready,

    output logic                              rsp_val,
    output logic [fetch_pkg::PACKET_BITS-1:0] rsp_packet,
    input  logic                              rsp_rdy
);

    import fetch_pkg::*;

    logic [PACKET_BITS-1:0] mem [mem_packets];
    logic                   running;    // low until the first edge after reset.
    logic                   rd_fire;
    logic                   wr_fire;

    // reads wait for the held response to drain. Writes do not.
    assign mem_ready = running && (mem_we || !rsp_val || rsp_rdy);

    assign rd_fire = mem_en && !mem_we && mem_ready;
    assign wr_fire = mem_en && mem_we && mem_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            running <= 1'b0;
            rsp_val <= 1'b0;
        end else begin
            running <= 1'b1;
            if (rd_fire) begin
                rsp_val <= 1'b1;
            end else if (rsp_rdy) begin
                rsp_val <= 1'b0;    // response taken.
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_fire) begin
            mem[mem_addr] <= mem_wdata;
        end
        if (rd_fire) begin
            rsp_packet <= mem[mem_addr];
        end
    end

    // a held response must not change, not even under a write to its address.
    a_rsp_hold: assert property (@(posedge clk) disable iff (rst)
        (rsp_val && !rsp_rdy) |=> (rsp_val && $stable(rsp_packet)));

endmodule

`default_nettype wire

// File: verilog.f
source/fetch_pkg.sv
source/inst_buffer.sv
source/fetch.sv
source/imem_arbiter.sv
source/inst_mem.sv
source/fetch_top.sv
bench/fetch_tb.sv
